// File: hw/fetch_pkg.sv
// BTB geometry, counter encodings and the fetch address union
`default_nettype none

package fetch_pkg;

    // ------------------------------------------------------------------------
    // Address and BTB geometry
    // ------------------------------------------------------------------------
    localparam int ADDR_W      = 32;
    localparam int OFFSET_W    = 2;
    localparam int SET_W       = 3;
    localparam int SETS        = 8;
    localparam int WAYS        = 2;
    localparam int TAG_W       = ADDR_W - SET_W - OFFSET_W;
    localparam int INSTR_BYTES = 4;

    // ------------------------------------------------------------------------
    // 2-bit saturating counter
    // ------------------------------------------------------------------------
    // Upper bit set means predict taken
    localparam int CTR_W = 2;

    localparam logic [CTR_W-1:0] CTR_RESET         = 2'b01;
    localparam logic [CTR_W-1:0] CTR_NEW_TAKEN     = 2'b10;
    localparam logic [CTR_W-1:0] CTR_NEW_NOT_TAKEN = 2'b01;

    // ------------------------------------------------------------------------
    // Fetch address, seen whole or split into BTB fields
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [SET_W-1:0]    set;
        logic [OFFSET_W-1:0] offset;
    } btb_addr_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        btb_addr_fields_t  f;
    } btb_addr_u;

endpackage

`default_nettype wire

// File: hw/btb_if.sv
// BTB read-port and write-port interfaces
`timescale 1ns/1ps
`default_nettype none

// One read port: the reader picks the set, the array returns both ways
interface btb_rd_if;

    logic [fetch_pkg::SET_W-1:0]                          set;
    logic [fetch_pkg::WAYS-1:0]                           way_valid;
    logic [fetch_pkg::WAYS-1:0][fetch_pkg::TAG_W-1:0]     way_tag;
    logic [fetch_pkg::WAYS-1:0][fetch_pkg::ADDR_W-1:0]    way_target;
    logic [fetch_pkg::WAYS-1:0][fetch_pkg::CTR_W-1:0]     way_ctr;
    // Names the least recently used way of the set
    logic                                                 lru;

    modport file (
        input  set,
        output way_valid, way_tag, way_target, way_ctr, lru
    );

    modport reader (
        output set,
        input  way_valid, way_tag, way_target, way_ctr, lru
    );

endinterface

// Write port, one way per cycle plus the set's LRU bit
interface btb_wr_if;

    logic                          wr_en;
    logic [fetch_pkg::SET_W-1:0]   wr_set;
    logic                          wr_way;
    logic                          wr_valid;
    logic [fetch_pkg::TAG_W-1:0]   wr_tag;
    logic [fetch_pkg::ADDR_W-1:0]  wr_target;
    logic [fetch_pkg::CTR_W-1:0]   wr_ctr;
    logic                          lru_en;
    logic                          lru_val;

    modport writer (
        output wr_en, wr_set, wr_way, wr_valid, wr_tag, wr_target, wr_ctr,
        output lru_en, lru_val
    );

    modport file (
        input  wr_en, wr_set, wr_way, wr_valid, wr_tag, wr_target, wr_ctr,
        input  lru_en, lru_val
    );

endinterface

`default_nettype wire

// File: hw/btb_array.sv
// BTB storage with two asynchronous read ports, one write port and LRU bits
`timescale 1ns/1ps
`default_nettype none

module btb_array (
    input  logic      clk,
    input  logic      rst,
    btb_rd_if.file    fetch_rd,
    btb_rd_if.file    update_rd,
    btb_wr_if.file    wr
);

    // ------------------------------------------------------------------------
    // Storage, one row per set holding every way
    // ------------------------------------------------------------------------
    logic [fetch_pkg::WAYS-1:0]                          valid_q  [fetch_pkg::SETS];
    logic [fetch_pkg::WAYS-1:0][fetch_pkg::TAG_W-1:0]    tag_q    [fetch_pkg::SETS];
    logic [fetch_pkg::WAYS-1:0][fetch_pkg::ADDR_W-1:0]   target_q [fetch_pkg::SETS];
    logic [fetch_pkg::WAYS-1:0][fetch_pkg::CTR_W-1:0]    ctr_q    [fetch_pkg::SETS];
    logic [fetch_pkg::SETS-1:0]                          lru_q;

    // ------------------------------------------------------------------------
    // Read ports
    // ------------------------------------------------------------------------
    // Fetch side
    assign fetch_rd.way_valid  = valid_q[fetch_rd.set];
    assign fetch_rd.way_tag    = tag_q[fetch_rd.set];
    assign fetch_rd.way_target = target_q[fetch_rd.set];
    assign fetch_rd.way_ctr    = ctr_q[fetch_rd.set];
    assign fetch_rd.lru        = lru_q[fetch_rd.set];

    // Update side, indexed by the branch being resolved
    assign update_rd.way_valid  = valid_q[update_rd.set];
    assign update_rd.way_tag    = tag_q[update_rd.set];
    assign update_rd.way_target = target_q[update_rd.set];
    assign update_rd.way_ctr    = ctr_q[update_rd.set];
    assign update_rd.lru        = lru_q[update_rd.set];

    // ------------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < fetch_pkg::SETS; s++) begin
                valid_q[s]  <= '0;
                tag_q[s]    <= '0;
                target_q[s] <= '0;
                ctr_q[s]    <= {fetch_pkg::WAYS{fetch_pkg::CTR_RESET}};
            end
            lru_q <= '0;
        end else begin
            if (wr.wr_en) begin
                valid_q[wr.wr_set][wr.wr_way]  <= wr.wr_valid;
                tag_q[wr.wr_set][wr.wr_way]    <= wr.wr_tag;
                target_q[wr.wr_set][wr.wr_way] <= wr.wr_target;
                ctr_q[wr.wr_set][wr.wr_way]    <= wr.wr_ctr;
            end
            if (wr.lru_en) begin
                lru_q[wr.wr_set] <= wr.lru_val;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/btb_lookup.sv
// Fetch-side BTB tag compare and prediction
`timescale 1ns/1ps
`default_nettype none

module btb_lookup (
    input  fetch_pkg::btb_addr_u         pc,
    btb_rd_if.reader                     rd,
    output logic                         predict_taken,
    output logic [fetch_pkg::ADDR_W-1:0] predict_target
);

    logic                         hit0;
    logic                         hit1;
    logic [fetch_pkg::CTR_W-1:0]  hit_ctr;
    logic [fetch_pkg::ADDR_W-1:0] hit_target;
    logic [fetch_pkg::ADDR_W-1:0] seq_pc;

    assign rd.set = pc.f.set;

    assign hit0 = rd.way_valid[0] && (rd.way_tag[0] == pc.f.tag);
    assign hit1 = rd.way_valid[1] && (rd.way_tag[1] == pc.f.tag);

    // Way 0 takes priority if both ways match
    assign hit_ctr    = hit0 ? rd.way_ctr[0]    : rd.way_ctr[1];
    assign hit_target = hit0 ? rd.way_target[0] : rd.way_target[1];

    assign seq_pc = pc.raw + fetch_pkg::ADDR_W'(fetch_pkg::INSTR_BYTES);

    always_comb begin
        if ((hit0 || hit1) && hit_ctr[fetch_pkg::CTR_W-1]) begin
            predict_taken  = 1'b1;
            predict_target = hit_target;
        end else begin
            // Miss or weak/strong not taken, fall through
            predict_taken  = 1'b0;
            predict_target = seq_pc;
        end
    end

endmodule

`default_nettype wire

// File: hw/btb_update.sv
// Execute-side BTB update: hit detection, victim choice, counter and LRU
`timescale 1ns/1ps
`default_nettype none

module btb_update (
    input  logic                         update_en,
    input  fetch_pkg::btb_addr_u         update_pc,
    input  logic                         actual_taken,
    input  logic [fetch_pkg::ADDR_W-1:0] update_target,
    btb_rd_if.reader                     rd,
    btb_wr_if.writer                     wr
);

    // ------------------------------------------------------------------------
    // Saturating counter step toward the resolved outcome
    // ------------------------------------------------------------------------
    function automatic logic [fetch_pkg::CTR_W-1:0] ctr_step(
        input logic [fetch_pkg::CTR_W-1:0] ctr,
        input logic                        taken
    );
        logic [fetch_pkg::CTR_W-1:0] nxt;
        nxt = ctr;
        if (taken && ctr != '1) begin
            nxt = ctr + 1'b1;
        end else if (!taken && ctr != '0) begin
            nxt = ctr - 1'b1;
        end
        return nxt;
    endfunction

    logic                        hit0;
    logic                        hit1;
    logic                        way_sel;
    logic [fetch_pkg::CTR_W-1:0] new_ctr;

    assign rd.set = update_pc.f.set;

    assign hit0 = rd.way_valid[0] && (rd.way_tag[0] == update_pc.f.tag);
    assign hit1 = rd.way_valid[1] && (rd.way_tag[1] == update_pc.f.tag);

    // ------------------------------------------------------------------------
    // Way and counter selection
    // ------------------------------------------------------------------------
    always_comb begin
        if (hit0) begin
            way_sel = 1'b0;
            new_ctr = ctr_step(rd.way_ctr[0], actual_taken);
        end else if (hit1) begin
            way_sel = 1'b1;
            new_ctr = ctr_step(rd.way_ctr[1], actual_taken);
        end else begin
            // Allocate, filling empty ways before evicting
            if (!rd.way_valid[0]) begin
                way_sel = 1'b0;
            end else if (!rd.way_valid[1]) begin
                way_sel = 1'b1;
            end else begin
                way_sel = rd.lru;
            end
            new_ctr = actual_taken ? fetch_pkg::CTR_NEW_TAKEN
                                   : fetch_pkg::CTR_NEW_NOT_TAKEN;
        end
    end

    // ------------------------------------------------------------------------
    // Write command
    // ------------------------------------------------------------------------
    assign wr.wr_en     = update_en;
    assign wr.wr_set    = update_pc.f.set;
    assign wr.wr_way    = way_sel;
    assign wr.wr_valid  = 1'b1;
    assign wr.wr_tag    = update_pc.f.tag;
    assign wr.wr_target = update_target;
    assign wr.wr_ctr    = new_ctr;

    // The way just touched becomes MRU, so the LRU bit names the other one
    assign wr.lru_en  = update_en;
    assign wr.lru_val = ~way_sel;

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
// Instruction fetch front end: PC register, next-PC choice and 2-way BTB
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                         clk,
    input  logic                         rst,

    // Stall from the hazard unit, low holds the PC
    input  logic                         pc_en,

    // Branch resolution from execute
    input  logic                         modify_pc_ex,
    input  logic [fetch_pkg::ADDR_W-1:0] update_pc_ex,
    input  logic                         update_btb_ex,
    input  logic [fetch_pkg::ADDR_W-1:0] pc_ex,
    input  logic [fetch_pkg::ADDR_W-1:0] jump_addr_ex,
    input  logic                         ex_branch_taken,

    // To the decode stage
    output logic [fetch_pkg::ADDR_W-1:0] pc_if,
    output logic                         predicted_taken_if,
    output logic [fetch_pkg::ADDR_W-1:0] predicted_target_if
);

    fetch_pkg::btb_addr_u         pc_q;
    fetch_pkg::btb_addr_u         upd_pc;
    logic [fetch_pkg::ADDR_W-1:0] pc_next;

    btb_rd_if fetch_rd ();
    btb_rd_if update_rd ();
    btb_wr_if upd_wr ();

    // ------------------------------------------------------------------------
    // PC register and next-PC selection
    // ------------------------------------------------------------------------
    // Lookup already gives PC + 4 when not predicting taken,
    // so its target covers both the prediction and the sequential case
    always_comb begin
        if (modify_pc_ex) begin
            pc_next = update_pc_ex;
        end else begin
            pc_next = predicted_target_if;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q.raw <= '0;
        end else if (pc_en) begin
            pc_q.raw <= pc_next;
        end
    end

    assign pc_if      = pc_q.raw;
    assign upd_pc.raw = pc_ex;

    // ------------------------------------------------------------------------
    // BTB
    // ------------------------------------------------------------------------
    btb_lookup u_lookup (
        .pc             (pc_q),
        .rd             (fetch_rd.reader),
        .predict_taken  (predicted_taken_if),
        .predict_target (predicted_target_if)
    );

    btb_update u_update (
        .update_en     (update_btb_ex),
        .update_pc     (upd_pc),
        .actual_taken  (ex_branch_taken),
        .update_target (jump_addr_ex),
        .rd            (update_rd.reader),
        .wr            (upd_wr.writer)
    );

    btb_array u_array (
        .clk       (clk),
        .rst       (rst),
        .fetch_rd  (fetch_rd.file),
        .update_rd (update_rd.file),
        .wr        (upd_wr.file)
    );

endmodule

`default_nettype wire

// File: tests/fetch_unit_chk.sv
// Concurrent assertions on the fetch_unit ports, bound into the DUT
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_chk (
    input logic                         clk,
    input logic                         rst,
    input logic                         pc_en,
    input logic [fetch_pkg::ADDR_W-1:0] pc_if,
    input logic                         predicted_taken_if,
    input logic [fetch_pkg::ADDR_W-1:0] predicted_target_if
);

    // Stall holds the PC
    assert property (@(posedge clk) disable iff (rst) !pc_en |=> $stable(pc_if))
        else $error("pc_if changed over a stalled cycle");

    // Not taken falls through to the next word
    assert property (@(posedge clk) disable iff (rst)
                     !predicted_taken_if |-> predicted_target_if == pc_if + 32'd4)
        else $error("predicted_target_if is not pc_if plus 4 while not taken");

    assert property (@(posedge clk) $fell(rst) |-> pc_if == '0)
        else $error("pc_if not 0 right after reset release");

endmodule

bind fetch_unit fetch_unit_chk chk0 (
    .clk                 (clk),
    .rst                 (rst),
    .pc_en               (pc_en),
    .pc_if               (pc_if),
    .predicted_taken_if  (predicted_taken_if),
    .predicted_target_if (predicted_target_if)
);

`default_nettype wire

// File: tests/btb_model.svh
// Reference model of the BTB contents and the fetch PC
`ifndef BTB_MODEL_SVH
`define BTB_MODEL_SVH

// Model state, one entry per set and way
logic                         m_valid  [fetch_pkg::SETS][fetch_pkg::WAYS];
logic [fetch_pkg::TAG_W-1:0]  m_tag    [fetch_pkg::SETS][fetch_pkg::WAYS];
logic [fetch_pkg::ADDR_W-1:0] m_target [fetch_pkg::SETS][fetch_pkg::WAYS];
logic [fetch_pkg::CTR_W-1:0]  m_ctr    [fetch_pkg::SETS][fetch_pkg::WAYS];
logic                         m_lru    [fetch_pkg::SETS];
logic [fetch_pkg::ADDR_W-1:0] m_pc;

task automatic model_reset();
    for (int s = 0; s < fetch_pkg::SETS; s++) begin
        for (int w = 0; w < fetch_pkg::WAYS; w++) begin
            m_valid[s][w]  = 1'b0;
            m_tag[s][w]    = '0;
            m_target[s][w] = '0;
            m_ctr[s][w]    = fetch_pkg::CTR_RESET;
        end
        m_lru[s] = 1'b0;
    end
    m_pc = '0;
endtask

function automatic int set_index(input logic [fetch_pkg::ADDR_W-1:0] addr);
    return int'(addr[fetch_pkg::OFFSET_W +: fetch_pkg::SET_W]);
endfunction

// Lowest matching way, -1 on a miss
function automatic int find_way(input logic [fetch_pkg::ADDR_W-1:0] addr);
    int s;
    int way;
    s   = set_index(addr);
    way = -1;
    for (int w = fetch_pkg::WAYS - 1; w >= 0; w--) begin
        if (m_valid[s][w] && m_tag[s][w] == addr[fetch_pkg::ADDR_W-1 -: fetch_pkg::TAG_W]) begin
            way = w;
        end
    end
    return way;
endfunction

task automatic model_predict(output logic taken, output logic [fetch_pkg::ADDR_W-1:0] target);
    int s;
    int w;
    s      = set_index(m_pc);
    w      = find_way(m_pc);
    taken  = 1'b0;
    target = m_pc + fetch_pkg::ADDR_W'(fetch_pkg::INSTR_BYTES);
    if (w >= 0 && m_ctr[s][w][fetch_pkg::CTR_W-1]) begin
        taken  = 1'b1;
        target = m_target[s][w];
    end
endtask

task automatic model_update(input logic [fetch_pkg::ADDR_W-1:0] addr, input logic taken,
                            input logic [fetch_pkg::ADDR_W-1:0] target);
    int s;
    int w;
    s = set_index(addr);
    w = find_way(addr);
    if (w >= 0) begin
        if (taken && m_ctr[s][w] != '1) begin
            m_ctr[s][w] = m_ctr[s][w] + fetch_pkg::CTR_W'(1);
        end else if (!taken && m_ctr[s][w] != '0) begin
            m_ctr[s][w] = m_ctr[s][w] - fetch_pkg::CTR_W'(1);
        end
    end else begin
        // Empty ways first, then the LRU way
        if (!m_valid[s][0]) begin
            w = 0;
        end else if (!m_valid[s][1]) begin
            w = 1;
        end else begin
            w = int'(m_lru[s]);
        end
        m_ctr[s][w] = taken ? fetch_pkg::CTR_NEW_TAKEN : fetch_pkg::CTR_NEW_NOT_TAKEN;
    end
    m_valid[s][w]  = 1'b1;
    m_tag[s][w]    = addr[fetch_pkg::ADDR_W-1 -: fetch_pkg::TAG_W];
    m_target[s][w] = target;
    m_lru[s]       = (w == 0);
endtask

// One clock edge: next PC from the old contents, then the BTB write
task automatic model_advance(input logic en, input logic modify,
                             input logic [fetch_pkg::ADDR_W-1:0] new_pc, input logic upd,
                             input logic [fetch_pkg::ADDR_W-1:0] br_pc, input logic taken,
                             input logic [fetch_pkg::ADDR_W-1:0] target);
    logic                         p_taken;
    logic [fetch_pkg::ADDR_W-1:0] p_target;
    model_predict(p_taken, p_target);
    if (en) begin
        if (modify) begin
            m_pc = new_pc;
        end else if (p_taken) begin
            m_pc = p_target;
        end else begin
            m_pc = m_pc + fetch_pkg::ADDR_W'(fetch_pkg::INSTR_BYTES);
        end
    end
    if (upd) begin
        model_update(br_pc, taken, target);
    end
endtask

`endif

// File: tests/tb_fetch_unit.sv
// Testbench for fetch_unit: clock, reset, stimulus table and checks against the model
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit;

    localparam int RESET_CYCLES  = 8;
    localparam int RESET_TIMEOUT = 20;

    // Branch PCs and targets; A, B and C share set 4
    localparam logic [31:0] BR_PC  = 32'h0000_1008;
    localparam logic [31:0] BR_TGT = 32'h0000_2000;
    localparam logic [31:0] A_PC   = 32'h0000_3010;
    localparam logic [31:0] B_PC   = 32'h0000_5010;
    localparam logic [31:0] C_PC   = 32'h0000_7010;

    logic        clk;
    logic        rst;
    logic        pc_en;
    logic        modify_pc_ex;
    logic [31:0] update_pc_ex;
    logic        update_btb_ex;
    logic [31:0] pc_ex;
    logic [31:0] jump_addr_ex;
    logic        ex_branch_taken;
    logic [31:0] pc_if;
    logic        predicted_taken_if;
    logic [31:0] predicted_target_if;

    typedef struct packed {
        logic        pc_en;
        logic        modify;
        logic [31:0] new_pc;
        logic        upd;
        logic [31:0] br_pc;
        logic        taken;
        logic [31:0] target;
    } stim_row_t;

    stim_row_t rows [$];
    integer    seed;

    `include "btb_model.svh"

    fetch_unit dut0 (
        .clk                 (clk),
        .rst                 (rst),
        .pc_en               (pc_en),
        .modify_pc_ex        (modify_pc_ex),
        .update_pc_ex        (update_pc_ex),
        .update_btb_ex       (update_btb_ex),
        .pc_ex               (pc_ex),
        .jump_addr_ex        (jump_addr_ex),
        .ex_branch_taken     (ex_branch_taken),
        .pc_if               (pc_if),
        .predicted_taken_if  (predicted_taken_if),
        .predicted_target_if (predicted_target_if)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic add_row(input logic en, input logic modify, input logic [31:0] new_pc,
                           input logic upd, input logic [31:0] br_pc, input logic taken,
                           input logic [31:0] target);
        stim_row_t r;
        r = '{en, modify, new_pc, upd, br_pc, taken, target};
        rows.push_back(r);
    endtask

    // Free-running fetch, execute-side buses carry random values
    task automatic add_padding(input int n);
        for (int i = 0; i < n; i++) begin
            add_row(1'b1, 1'b0, '0, 1'b0, $random(seed), 1'b0, $random(seed));
        end
    endtask

    task automatic build_table();
        add_padding(3);
        // Stalled, the redirect is dropped
        add_row(1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
        add_row(1'b0, 1'b1, 32'h0000_0200, 1'b0, '0, 1'b0, '0);
        add_row(1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
        add_row(1'b1, 1'b1, 32'h0000_1000, 1'b0, '0, 1'b0, '0);
        // ------------------------------------------------------------------------
        // Counter training on one branch
        // ------------------------------------------------------------------------
        add_row(1'b1, 1'b0, '0, 1'b1, BR_PC, 1'b1, BR_TGT);
        add_padding(4);
        add_row(1'b1, 1'b0, '0, 1'b1, BR_PC, 1'b0, BR_TGT);
        add_row(1'b1, 1'b0, '0, 1'b1, BR_PC, 1'b0, BR_TGT);
        add_row(1'b1, 1'b1, BR_PC, 1'b0, '0, 1'b0, '0);
        add_padding(2);
        // Back to 01, still not taken
        add_row(1'b1, 1'b0, '0, 1'b1, BR_PC, 1'b1, BR_TGT);
        add_row(1'b1, 1'b1, BR_PC, 1'b0, '0, 1'b0, '0);
        add_padding(2);
        // ------------------------------------------------------------------------
        // LRU replacement in set 4
        // ------------------------------------------------------------------------
        add_row(1'b1, 1'b0, '0, 1'b1, A_PC, 1'b1, 32'h0000_4000);
        add_row(1'b1, 1'b0, '0, 1'b1, B_PC, 1'b1, 32'h0000_6000);
        add_row(1'b1, 1'b0, '0, 1'b1, C_PC, 1'b1, 32'h0000_8000);
        for (int i = 0; i < 3; i++) begin
            add_row(1'b1, 1'b1, (i == 0) ? A_PC : (i == 1) ? B_PC : C_PC, 1'b0, '0, 1'b0, '0);
            add_padding(1);
        end
        // Touch B, then A comes back in place of C (update while stalled)
        add_row(1'b1, 1'b1, B_PC, 1'b0, '0, 1'b0, '0);
        add_row(1'b1, 1'b0, '0, 1'b1, B_PC, 1'b1, 32'h0000_6000);
        add_row(1'b0, 1'b0, '0, 1'b1, A_PC, 1'b1, 32'h0000_4000);
        for (int i = 0; i < 3; i++) begin
            add_row(1'b1, 1'b1, (i == 0) ? C_PC : (i == 1) ? A_PC : B_PC, 1'b0, '0, 1'b0, '0);
            add_padding(1);
        end
        // Redirect wins over a taken prediction of B
        add_row(1'b1, 1'b1, B_PC, 1'b0, '0, 1'b0, '0);
        add_row(1'b1, 1'b1, 32'h0000_0100, 1'b0, '0, 1'b0, '0);
        add_padding(3);
    endtask

    task automatic report_failure();
        $display("test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_outputs();
        logic        exp_taken;
        logic [31:0] exp_target;
        model_predict(exp_taken, exp_target);
        check_word("pc_if", m_pc, pc_if);
        check_word("predicted_taken_if", {31'b0, exp_taken}, {31'b0, predicted_taken_if});
        check_word("predicted_target_if", exp_target, predicted_target_if);
    endtask

    task automatic apply_row(input stim_row_t r);
        pc_en           = r.pc_en;
        modify_pc_ex    = r.modify;
        update_pc_ex    = r.new_pc;
        update_btb_ex   = r.upd;
        pc_ex           = r.br_pc;
        ex_branch_taken = r.taken;
        jump_addr_ex    = r.target;
    endtask

    task automatic wait_reset_state();
        int cycles;
        cycles = 0;
        while (pc_if !== '0 || predicted_taken_if !== 1'b0) begin
            if (cycles >= RESET_TIMEOUT) begin
                $display("Timeout: pc_if did not read 0 after reset was released");
                report_failure();
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    initial begin
        seed        = 32'h53f5;
        rst         = 1'b1;
        apply_row('0);
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        wait_reset_state();
        model_reset();
        for (int i = 0; i < rows.size(); i++) begin
            check_outputs();
            apply_row(rows[i]);
            model_advance(rows[i].pc_en, rows[i].modify, rows[i].new_pc, rows[i].upd,
                          rows[i].br_pc, rows[i].taken, rows[i].target);
            @(posedge clk);
            #1;
        end
        check_outputs();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+tests
hw/fetch_pkg.sv
hw/btb_if.sv
hw/btb_array.sv
hw/btb_lookup.sv
hw/btb_update.sv
hw/fetch_unit.sv
tests/fetch_unit_chk.sv
tests/tb_fetch_unit.sv

// File: Makefile
# Verilator build and run of the fetch unit testbench
VERILATOR ?= verilator
TOP       ?= tb_fetch_unit
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := tests/btb_model.svh
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -qx 'test passed' $(LOG) || { echo "FAIL: see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
